// ==== vlog.f ====
+incdir+rtl
rtl/aud_types_pkg.sv
rtl/aud_bus_pkg.sv
rtl/aud_recorder.sv
rtl/aud_player.sv
rtl/aud_sram_ctrl.sv
rtl/aud_top.sv
bench/i2s_codec_model.sv
bench/tb_aud_top.sv

// ==== Bender.yml ====
package:
  name: aud_codec_sram

sources:
  # rtl
  - include_dirs:
      - rtl
    files:
      - rtl/aud_types_pkg.sv
      - rtl/aud_bus_pkg.sv
      - rtl/aud_recorder.sv
      - rtl/aud_player.sv
      - rtl/aud_sram_ctrl.sv
      - rtl/aud_top.sv

  # bench
  - target: test
    files:
      - bench/i2s_codec_model.sv
      - bench/tb_aud_top.sv

// ==== bench/tb_aud_top.sv ====
`timescale 1ns/1ps

module tb_aud_top
    import aud_types_pkg::*, aud_bus_pkg::*;
;

    localparam int CLK_NS      = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int FRAME_CLKS  = 40;
    localparam int MEM_WORDS   = 8;
    localparam int MODEL_WORDS = 16;
    localparam int SAMPLE_W    = $bits(sample_t);
    // frames for record/stop, play, play/stop, pause and full
    localparam int RUN_FRAMES  = 8 + 8 + 5 + 8 + 13;
    localparam int WATCHDOG_NS = RUN_FRAMES * FRAME_CLKS * CLK_NS + 10 * FRAME_CLKS * CLK_NS;

    typedef enum int {
        BTN_REC_START,
        BTN_REC_PAUSE,
        BTN_REC_STOP,
        BTN_PLAY_START,
        BTN_PLAY_STOP
    } button_e;

    logic       clk;
    logic       rst_n;
    logic       lrc;
    logic       adcdat;
    logic       rec_start;
    logic       rec_pause;
    logic       rec_stop;
    logic       play_start;
    logic       play_stop;
    logic       dacdat;
    logic       rec_finish;
    logic       play_finish;
    sram_pins_t sram;
    sample_t    sram_rdata;

    sample_t     mem [MODEL_WORDS];
    sample_t     exp_mem [MODEL_WORDS];
    logic [31:0] lfsr;
    int          err_cnt      = 0;
    int          rec_fin_cnt  = 0;
    int          play_fin_cnt = 0;

    aud_top #(
        .P_MEM_WORDS (MEM_WORDS)
    ) uut (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_lrc         (lrc),
        .i_adcdat      (adcdat),
        .i_rec_start   (rec_start),
        .i_rec_pause   (rec_pause),
        .i_rec_stop    (rec_stop),
        .i_play_start  (play_start),
        .i_play_stop   (play_stop),
        .o_dacdat      (dacdat),
        .o_rec_finish  (rec_finish),
        .o_play_finish (play_finish),
        .o_sram        (sram),
        .i_sram_rdata  (sram_rdata)
    );

    i2s_codec_model codec (
        .i_clk    (clk),
        .i_dacdat (dacdat),
        .o_lrc    (lrc),
        .o_adcdat (adcdat)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    //////////////////////////////
    // SRAM model and finish counters
    assign sram_rdata = (sram.oe_n === 1'b0) ? mem[sram.addr[3:0]] : '0;

    always @(posedge clk) begin
        if (sram.we_n === 1'b0) begin
            if (sram.addr >= MODEL_WORDS) begin
                $display("SRAM write outside the model range, address %0d", sram.addr);
                stop_run();
            end else begin
                mem[sram.addr[3:0]] <= sram.wdata;
            end
        end
    end

    always @(negedge clk) begin
        if (rec_finish === 1'b1)
            rec_fin_cnt++;
        if (play_finish === 1'b1)
            play_fin_cnt++;
    end

    //////////////////////////////
    // helpers
    function automatic sample_t fill_word(int a);
        return sample_t'((a * 32'h9e37_79b9) >> 13) ^ 16'ha5c3;
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_sample(output sample_t v);
        int b;
        v = '0;
        for (b = 0; b < SAMPLE_W; b++) begin
            lfsr = lfsr_next(lfsr);     // one step per bit
            v    = {v[SAMPLE_W-2:0], lfsr[0]};
        end
    endtask

    task automatic stop_run();
        err_cnt++;
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after a failure");
    endtask

    task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_memory(string tag);
        int a;
        for (a = 0; a < MODEL_WORDS; a++)
            check_eq($sformatf("%s mem[%0d]", tag, a), mem[a], exp_mem[a]);
    endtask

    // strobes high, DAC line and finish outputs low
    task automatic check_idle_outputs();
        check_eq("we_n after reset", sram.we_n, 1);
        check_eq("oe_n after reset", sram.oe_n, 1);
        check_eq("dacdat after reset", dacdat, 0);
        check_eq("rec_finish after reset", rec_finish, 0);
        check_eq("play_finish after reset", play_finish, 0);
    endtask

    task automatic set_button(button_e b, logic v);
        case (b)
            BTN_REC_START:  rec_start  = v;
            BTN_REC_PAUSE:  rec_pause  = v;
            BTN_REC_STOP:   rec_stop   = v;
            BTN_PLAY_START: play_start = v;
            default:        play_stop  = v;
        endcase
    endtask

    // one cycle press that returns once the release edge is seen
    task automatic press_button(button_e b);
        set_button(b, 1'b1);
        @(posedge clk);
        #DRIVE_DLY;
        set_button(b, 1'b0);
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
    endtask

    // next edge at which the codec has driven frame step s
    task automatic step_to(int s);
        do
            @(posedge clk);
        while (codec.step != s);
        #DRIVE_DLY;
    endtask

    task automatic wait_finish(bit play, int base, int max_frames);
        int n;
        n = 0;
        while (((play ? play_fin_cnt : rec_fin_cnt) == base) && n < max_frames * FRAME_CLKS) begin
            @(negedge clk);
            n++;
        end
        if ((play ? play_fin_cnt : rec_fin_cnt) == base) begin
            $display("%s finish pulse did not arrive within %0d frames",
                     play ? "player" : "recorder", max_frames);
            stop_run();
        end
    endtask

    //////////////////////////////
    // directed tests
    task automatic record_and_stop();
        sample_t s;
        int      base;
        int      i;
        step_to(24);
        base = rec_fin_cnt;
        for (i = 0; i < 5; i++) begin
            next_sample(s);
            codec.adc_q.push_back(s);
            exp_mem[i] = s;
        end
        press_button(BTN_REC_START);    // next frame is the first captured
        repeat (5) step_to(24);
        press_button(BTN_REC_STOP);
        wait_finish(1'b0, base, 2);
        repeat (4) @(negedge clk);
        check_eq("record/stop finish pulses", rec_fin_cnt - base, 1);
        check_memory("record/stop");
    endtask

    task automatic play_all();
        sample_t got[$];
        int      base;
        int      i;
        step_to(24);
        base = play_fin_cnt;
        codec.dac_q.delete();
        press_button(BTN_PLAY_START);
        wait_finish(1'b1, base, 8);
        got = codec.dac_q;
        check_eq("playback word count", got.size(), 5);
        for (i = 0; i < 5; i++)
            check_eq($sformatf("playback word %0d", i), got[i], exp_mem[i]);
        repeat (4) @(negedge clk);
        check_eq("playback finish pulses", play_fin_cnt - base, 1);
    endtask

    task automatic play_with_stop();
        sample_t got[$];
        int      base;
        int      i;
        step_to(24);
        base = play_fin_cnt;
        codec.dac_q.delete();
        press_button(BTN_PLAY_START);
        repeat (2) step_to(24);         // second sample on the line
        press_button(BTN_PLAY_STOP);
        wait_finish(1'b1, base, 2);
        got = codec.dac_q;
        check_eq("stopped playback at most two words", got.size() <= 2, 1);
        for (i = 0; i < got.size(); i++)
            check_eq($sformatf("stopped playback word %0d", i), got[i], exp_mem[i]);
        repeat (4) @(negedge clk);
        check_eq("stopped playback finish pulses", play_fin_cnt - base, 1);
    endtask

    task automatic record_with_pause();
        sample_t s;
        int      base;
        int      i;
        step_to(24);
        base = rec_fin_cnt;
        for (i = 0; i < 6; i++) begin
            next_sample(s);
            codec.adc_q.push_back(s);
            if (i < 2)
                exp_mem[i] = s;
            else if (i >= 4)
                exp_mem[i - 2] = s;     // frames 2 and 3 fall in the pause
        end
        press_button(BTN_REC_START);
        repeat (2) step_to(24);
        press_button(BTN_REC_PAUSE);
        repeat (2) step_to(24);
        press_button(BTN_REC_PAUSE);
        repeat (2) step_to(24);
        press_button(BTN_REC_STOP);
        wait_finish(1'b0, base, 2);
        repeat (4) @(negedge clk);
        check_eq("pause finish pulses", rec_fin_cnt - base, 1);
        check_memory("pause");
    endtask

    task automatic record_until_full();
        sample_t s;
        int      base;
        int      i;
        step_to(24);
        base = rec_fin_cnt;
        for (i = 0; i < MEM_WORDS + 2; i++) begin
            next_sample(s);
            codec.adc_q.push_back(s);
            if (i < MEM_WORDS)
                exp_mem[i] = s;
        end
        press_button(BTN_REC_START);
        wait_finish(1'b0, base, MEM_WORDS + 2);
        repeat (3) step_to(24);         // frames after full must not land
        check_eq("full finish pulses", rec_fin_cnt - base, 1);
        check_memory("full");
    endtask

    //////////////////////////////
    // main sequence
    initial begin
        int a;
        rst_n      = 1'b1;
        rec_start  = 1'b0;
        rec_pause  = 1'b0;
        rec_stop   = 1'b0;
        play_start = 1'b0;
        play_stop  = 1'b0;
        lfsr       = 32'h8171_ae9f;
        for (a = 0; a < MODEL_WORDS; a++) begin
            mem[a]     = fill_word(a);
            exp_mem[a] = fill_word(a);
        end
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b0;
        check_idle_outputs();

        record_and_stop();
        play_all();             // plays the five words of the first recording
        play_with_stop();
        record_with_pause();
        record_until_full();

        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_run();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, tests still running after %0d ns", WATCHDOG_NS);
        stop_run();
    end

endmodule

// ==== bench/i2s_codec_model.sv ====
`timescale 1ns/1ps

module i2s_codec_model
    import aud_types_pkg::*;
(
    input  logic i_clk,
    input  logic i_dacdat,
    output logic o_lrc,
    output logic o_adcdat
);

    localparam int FRAME_LEN = 40;
    localparam int HALF_LEN  = 20;     // lrc low for the first half
    localparam int W         = $bits(sample_t);
    localparam int DRIVE_DLY = 2;

    sample_t adc_q[$];      // samples still to send one per frame
    sample_t dac_q[$];      // one word per frame seen on the DAC line
    int      step;          // frame position driven last

    sample_t tx;
    sample_t rx;
    int      k;

    initial begin
        o_lrc     = 1'b1;
        o_adcdat  = 1'b0;
        step      = FRAME_LEN - 1;
        tx        = '0;
        rx        = '0;
        forever begin
            for (k = 0; k < FRAME_LEN; k++) begin
                @(posedge i_clk);
                #DRIVE_DLY;
                if (k == 0)
                    tx = (adc_q.size() > 0) ? adc_q.pop_front() : '0;
                // DAC bit launched on the edge just passed
                if (k >= 1 && k <= W)
                    rx = {rx[W-2:0], i_dacdat};
                if (k == W)
                    dac_q.push_back(rx);
                o_lrc    = (k >= HALF_LEN);
                o_adcdat = (k < W) ? tx[W-1-k] : 1'b0;     // MSB first
                step     = k;
            end
        end
    end

endmodule

// ==== rtl/aud_top.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_top
    import aud_types_pkg::*, aud_bus_pkg::*;
#(
    parameter int P_MEM_WORDS = `AUD_MEM_WORDS
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_lrc,
    input  logic       i_adcdat,
    input  logic       i_rec_start,
    input  logic       i_rec_pause,
    input  logic       i_rec_stop,
    input  logic       i_play_start,
    input  logic       i_play_stop,
    output logic       o_dacdat,
    output logic       o_rec_finish,
    output logic       o_play_finish,
    output sram_pins_t o_sram,
    input  sample_t    i_sram_rdata
);

    logic       wr_req;
    logic       wr_ack;
    mem_wr_t    wr;
    logic       rd_req;
    logic       rd_ack;
    mem_rd_t    rd;
    sample_t    rd_data;
    sram_addr_t rec_len;    // words recorded, bounds playback

    aud_recorder #(
        .P_MEM_WORDS (P_MEM_WORDS)
    ) u_recorder (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_lrc    (i_lrc),
        .i_start  (i_rec_start),
        .i_pause  (i_rec_pause),
        .i_stop   (i_rec_stop),
        .i_adcdat (i_adcdat),
        .o_wr_req (wr_req),
        .o_wr     (wr),
        .i_wr_ack (wr_ack),
        .o_addr   (rec_len),
        .o_finish (o_rec_finish)
    );

    aud_player u_player (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_lrc     (i_lrc),
        .i_start   (i_play_start),
        .i_stop    (i_play_stop),
        .i_length  (rec_len),
        .o_rd_req  (rd_req),
        .o_rd      (rd),
        .i_rd_ack  (rd_ack),
        .i_rd_data (rd_data),
        .o_dacdat  (o_dacdat),
        .o_finish  (o_play_finish)
    );

    aud_sram_ctrl u_sram_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr_req     (wr_req),
        .o_wr_ack     (wr_ack),
        .i_wr         (wr),
        .i_rd_req     (rd_req),
        .o_rd_ack     (rd_ack),
        .i_rd         (rd),
        .o_rd_data    (rd_data),
        .o_sram       (o_sram),
        .i_sram_rdata (i_sram_rdata)
    );

endmodule

// ==== rtl/aud_sram_ctrl.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_sram_ctrl
    import aud_types_pkg::*, aud_bus_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_req,
    output logic       o_wr_ack,
    input  mem_wr_t    i_wr,
    input  logic       i_rd_req,
    output logic       o_rd_ack,
    input  mem_rd_t    i_rd,
    output sample_t    o_rd_data,
    output sram_pins_t o_sram,
    input  sample_t    i_sram_rdata
);

    typedef enum logic [1:0] {C_IDLE, C_ACCESS, C_GAP, C_ACK} ctrl_state_e;

    localparam logic [3:0] CYC_LAST = 4'(`AUD_SRAM_CYC - 1);

    ctrl_state_e state;
    logic        is_wr;
    logic [3:0]  cyc;
    logic        we_n;
    logic        oe_n;
    sram_addr_t  addr;
    sample_t     wdata;
    logic        req_held;

    assign req_held = is_wr ? i_wr_req : i_rd_req;
    assign o_sram   = '{addr: addr, wdata: wdata, we_n: we_n, oe_n: oe_n};

    //////////////////////////////
    // access FSM, writes first
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state    <= C_IDLE;
            is_wr    <= 1'b0;
            cyc      <= '0;
            we_n     <= 1'b1;
            oe_n     <= 1'b1;
            o_wr_ack <= 1'b0;
            o_rd_ack <= 1'b0;
        end else begin
            case (state)
                C_IDLE: begin
                    cyc <= '0;
                    if (i_wr_req) begin
                        is_wr <= 1'b1;
                        we_n  <= 1'b0;
                        state <= C_ACCESS;
                    end else if (i_rd_req) begin
                        is_wr <= 1'b0;
                        oe_n  <= 1'b0;
                        state <= C_ACCESS;
                    end
                end
                C_ACCESS: begin
                    cyc <= cyc + 4'd1;
                    if (cyc == CYC_LAST) begin
                        we_n  <= 1'b1;
                        oe_n  <= 1'b1;
                        state <= C_GAP;
                    end
                end
                C_GAP: begin
                    o_wr_ack <= is_wr;
                    o_rd_ack <= !is_wr;
                    state    <= C_ACK;
                end
                default: begin
                    if (!req_held) begin        // four-phase, ack drops after req
                        o_wr_ack <= 1'b0;
                        o_rd_ack <= 1'b0;
                        state    <= C_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == C_IDLE) begin
            if (i_wr_req) begin
                addr  <= i_wr.addr;
                wdata <= i_wr.data;
            end else if (i_rd_req) begin
                addr <= i_rd.addr;
            end
        end
        if (state == C_ACCESS && cyc == CYC_LAST && !is_wr)
            o_rd_data <= i_sram_rdata;  // last cycle with oe_n low
    end

    a_no_bus_clash: assert property (@(posedge i_clk) disable iff (i_rst_n)
        !(!o_sram.we_n && !o_sram.oe_n));

    // an ack only ever answers a live request of its own port
    a_ack_has_req: assert property (@(posedge i_clk) disable iff (i_rst_n)
        ($rose(o_wr_ack) |-> i_wr_req) and ($rose(o_rd_ack) |-> i_rd_req));

endmodule

// ==== rtl/aud_player.sv ====
`timescale 1ns/1ps

module aud_player
    import aud_types_pkg::*, aud_bus_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_lrc,
    input  logic        i_start,
    input  logic        i_stop,
    input  sram_addr_t  i_length,
    output logic        o_rd_req,
    output mem_rd_t     o_rd,
    input  logic        i_rd_ack,
    input  sample_t     i_rd_data,
    output logic        o_dacdat,
    output logic        o_finish
);

    localparam int W = $bits(sample_t);

    play_state_e state;
    sram_addr_t  rd_addr;       // next word to fetch
    sample_t     nxt_smp;       // prefetched word
    logic        nxt_vld;
    sample_t     shreg;
    bit_cnt_t    cnt;
    logic        lrc_d;
    logic        start_d;
    logic        stop_d;
    logic        stop_pend;

    logic lrc_fall;
    logic start_fall;
    logic active;
    logic stopping;
    logic stop_now;
    logic fetch0;
    logic rd_done;
    logic load;
    logic shifting;

    assign lrc_fall   = lrc_d & ~i_lrc;
    assign start_fall = start_d & ~i_start;
    assign active     = (state == PS_FETCH) || (state == PS_WAIT) || (state == PS_SHIFT);
    assign stopping   = active && (stop_pend || (stop_d & ~i_stop));
    assign stop_now   = stopping && !o_rd_req;  // let a pending read close first
    assign fetch0     = (state == PS_IDLE) && start_fall && (i_length != '0);
    assign rd_done    = o_rd_req && i_rd_ack;
    assign load       = lrc_fall && nxt_vld && !stopping &&
                        ((state == PS_WAIT) || (state == PS_SHIFT));
    assign shifting   = (state == PS_SHIFT) && !i_lrc && !lrc_fall && (cnt < bit_cnt_t'(W));
    assign o_finish   = (state == PS_FINISH);

    //////////////////////////////
    // FSM and serializer
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state     <= PS_IDLE;
            rd_addr   <= '0;
            nxt_vld   <= 1'b0;
            cnt       <= '0;
            o_rd_req  <= 1'b0;
            o_dacdat  <= 1'b0;
            lrc_d     <= 1'b0;
            start_d   <= 1'b0;
            stop_d    <= 1'b0;
            stop_pend <= 1'b0;
        end else begin
            lrc_d   <= i_lrc;
            start_d <= i_start;
            stop_d  <= i_stop;
            if (stopping)
                stop_pend <= 1'b1;

            if (load) begin
                o_dacdat <= nxt_smp[W-1];       // MSB right after the lrc edge
                cnt      <= bit_cnt_t'(1);
                nxt_vld  <= 1'b0;
                o_rd_req <= (rd_addr != i_length);
            end else if (shifting) begin
                o_dacdat <= shreg[W-1];
                cnt      <= cnt + 1'b1;
            end else begin
                o_dacdat <= 1'b0;
            end

            if (rd_done) begin
                o_rd_req <= 1'b0;
                nxt_vld  <= 1'b1;
                rd_addr  <= rd_addr + 1'b1;
            end

            case (state)
                PS_IDLE: begin
                    if (fetch0) begin
                        state     <= PS_FETCH;
                        o_rd_req  <= 1'b1;
                        rd_addr   <= '0;
                        nxt_vld   <= 1'b0;
                        stop_pend <= 1'b0;
                    end else if (start_fall) begin
                        state <= PS_FINISH;     // nothing recorded
                    end
                end
                PS_FETCH, PS_WAIT, PS_SHIFT: begin
                    if (stop_now) begin
                        state     <= PS_FINISH;
                        stop_pend <= 1'b0;
                    end else if (rd_done && state == PS_FETCH) begin
                        state <= PS_WAIT;
                    end else if (load) begin
                        state <= PS_SHIFT;
                    end else if (lrc_fall && state == PS_SHIFT && !nxt_vld && !o_rd_req) begin
                        state <= PS_FINISH;     // last sample is out
                    end
                end
                default: state <= PS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (rd_done)
            nxt_smp <= i_rd_data;
        if (load)
            shreg <= nxt_smp << 1;
        else if (shifting)
            shreg <= shreg << 1;
        if (fetch0)
            o_rd.addr <= '0;
        else if (load)
            o_rd.addr <= rd_addr;
    end

    // i_length comes from the recorder
    a_rd_in_range: assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_rd_req |-> (o_rd.addr < i_length));

endmodule

// ==== rtl/aud_recorder.sv ====
`timescale 1ns/1ps
`include "aud_defines.svh"

module aud_recorder
    import aud_types_pkg::*, aud_bus_pkg::*;
#(
    parameter int P_MEM_WORDS = `AUD_MEM_WORDS
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_lrc,
    input  logic       i_start,
    input  logic       i_pause,
    input  logic       i_stop,
    input  logic       i_adcdat,
    output logic       o_wr_req,
    output mem_wr_t    o_wr,
    input  logic       i_wr_ack,
    output sram_addr_t o_addr,
    output logic       o_finish
);

    localparam int         W         = $bits(sample_t);
    localparam sram_addr_t LAST_ADDR = sram_addr_t'(P_MEM_WORDS - 1);

    rec_state_e state;
    sample_t    shift;
    bit_cnt_t   cnt;
    logic       lrc_d;
    logic       start_d;
    logic       pause_d;
    logic       stop_d;
    logic       pause_tgl;      // pause/resume waiting for next frame
    logic       stop_pend;

    logic lrc_fall;
    logic start_fall;
    logic pause_fall;
    logic stop_fall;
    logic active;
    logic rec_next_frame;
    logic shift_en;
    logic word_done;
    logic full_hit;
    logic stop_now;

    //////////////////////////////
    // edges and capture control
    assign lrc_fall   = lrc_d & ~i_lrc;
    assign start_fall = start_d & ~i_start;     // act on button release
    assign pause_fall = pause_d & ~i_pause;
    assign stop_fall  = stop_d & ~i_stop;

    assign active = (state == RS_WAIT) || (state == RS_REC) || (state == RS_PAUSE);

    // does the frame starting now get captured
    assign rec_next_frame = active &&
                            (pause_tgl ? (state == RS_PAUSE) : (state != RS_PAUSE));

    assign shift_en  = lrc_fall ? rec_next_frame
                                : (state == RS_REC) && !i_lrc && (cnt != '0) &&
                                  (cnt < bit_cnt_t'(W));
    assign word_done = shift_en && !lrc_fall && (cnt == bit_cnt_t'(W - 1));
    assign full_hit  = o_wr_req && i_wr_ack && (o_addr == LAST_ADDR);
    assign stop_now  = (stop_pend || stop_fall) && !o_wr_req && !word_done;
    assign o_finish  = (state == RS_FINISH);

    //////////////////////////////
    // FSM
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            state     <= RS_IDLE;
            cnt       <= '0;
            o_addr    <= '0;
            o_wr_req  <= 1'b0;
            pause_tgl <= 1'b0;
            stop_pend <= 1'b0;
            lrc_d     <= 1'b0;
            start_d   <= 1'b0;
            pause_d   <= 1'b0;
            stop_d    <= 1'b0;
        end else begin
            lrc_d   <= i_lrc;
            start_d <= i_start;
            pause_d <= i_pause;
            stop_d  <= i_stop;

            if (pause_fall)
                pause_tgl <= ~pause_tgl;
            if (stop_fall && active)
                stop_pend <= 1'b1;
            if (shift_en)
                cnt <= lrc_fall ? bit_cnt_t'(1) : cnt + 1'b1;

            if (word_done)
                o_wr_req <= 1'b1;
            else if (i_wr_ack)
                o_wr_req <= 1'b0;
            if (o_wr_req && i_wr_ack)
                o_addr <= o_addr + 1'b1;    // word is in memory

            case (state)
                RS_IDLE: begin
                    if (start_fall) begin
                        state     <= RS_WAIT;
                        o_addr    <= '0;
                        pause_tgl <= 1'b0;
                        stop_pend <= 1'b0;
                    end
                end
                RS_WAIT, RS_REC, RS_PAUSE: begin
                    if (full_hit || stop_now) begin
                        state     <= RS_FINISH;
                        stop_pend <= 1'b0;
                    end else if (lrc_fall) begin
                        state     <= rec_next_frame ? RS_REC : RS_PAUSE;
                        pause_tgl <= pause_fall;
                    end
                end
                default: state <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (shift_en)
            shift <= {shift[W-2:0], i_adcdat};
        if (word_done)
            o_wr <= '{addr: o_addr, data: {shift[W-2:0], i_adcdat}};
    end

    // controller must have finished the last write before the next word is ready
    a_no_overrun: assert property (@(posedge i_clk) disable iff (i_rst_n)
        word_done |-> !o_wr_req);

    a_addr_range: assert property (@(posedge i_clk) disable iff (i_rst_n)
        int'(o_addr) <= P_MEM_WORDS);

endmodule

// ==== rtl/aud_bus_pkg.sv ====
package aud_bus_pkg;

    import aud_types_pkg::*;

    // recorder to controller, held stable while req is high
    typedef struct packed {
        sram_addr_t addr;
        sample_t    data;
    } mem_wr_t;

    // player to controller
    typedef struct packed {
        sram_addr_t addr;
    } mem_rd_t;

    // chip pins, strobes active low
    typedef struct packed {
        sram_addr_t addr;
        sample_t    wdata;
        logic       we_n;
        logic       oe_n;
    } sram_pins_t;

endpackage

// ==== rtl/aud_types_pkg.sv ====
`include "aud_defines.svh"

package aud_types_pkg;

    typedef logic [`AUD_SAMPLE_W-1:0] sample_t;
    typedef logic [`AUD_ADDR_W-1:0]   sram_addr_t;
    typedef logic [4:0]               bit_cnt_t;    // 0..16, bit position in half frame

    // recorder FSM
    typedef enum logic [2:0] {
        RS_IDLE,
        RS_WAIT,    // started, waiting for a frame boundary
        RS_REC,
        RS_PAUSE,
        RS_FINISH
    } rec_state_e;

    // player FSM
    typedef enum logic [2:0] {
        PS_IDLE,
        PS_FETCH,   // first word on its way from SRAM
        PS_WAIT,
        PS_SHIFT,
        PS_FINISH
    } play_state_e;

endpackage

// ==== rtl/aud_defines.svh ====
`ifndef AUD_DEFINES_SVH
`define AUD_DEFINES_SVH

// audio sample, left channel only
`define AUD_SAMPLE_W 16

// word address into the external 16-bit SRAM
`define AUD_ADDR_W 20

// recording depth in words, leaves headroom below 2**20
`define AUD_MEM_WORDS 1024000

// cycles a we_n / oe_n strobe stays low per access
`define AUD_SRAM_CYC 2

`endif
